// ==== src/dep_pkg.sv ====
// dep_pkg: widths, create packet and controller state encoding shared by the issue queue
`default_nettype none

package dep_pkg;

  // ========================================
  // widths and sizes
  // ========================================
  // physical register tag
  localparam int preg_w = 7;
  // number of queue slots
  localparam int iq_depth = 4;
  // longest producer latency in cycles
  localparam int lat_max = 3;
  localparam int lat_w = 2;
  // opcode is opaque to the queue
  localparam int op_w = 8;

  // ========================================
  // create packet, 33 bits
  // ========================================
  typedef struct packed {
    logic [op_w-1:0]   op;
    logic [preg_w-1:0] dst_preg;
    logic [lat_w-1:0]  lat;
    logic [preg_w-1:0] src0_preg;
    // set when the value is already in the register file
    logic              src0_rdy;
    logic [preg_w-1:0] src1_preg;
    logic              src1_rdy;
  } iq_create_t;

  // issue controller states
  typedef enum logic [1:0] {
    st_idle  = 2'd0,
    st_offer = 2'd1,
    st_flush = 2'd2
  } iq_state_t;

endpackage

`default_nettype wire

// ==== src/dep_bcast_if.sv ====
// dep_bcast_if: wake-up, cancel and write-back broadcasts watched by every source entry
`timescale 1ns/100ps
`default_nettype none

interface dep_bcast_if
  import dep_pkg::*;
();

  // speculative wake-up, driven by the timer
  logic              wake_vld;
  logic [preg_w-1:0] wake_preg;
  // drops every wake-up not yet backed by a write-back
  logic              wake_cancel;
  // two write-back ports
  logic              wb0_vld;
  logic [preg_w-1:0] wb0_preg;
  logic              wb1_vld;
  logic [preg_w-1:0] wb1_preg;

  // timer owns only the wake-up pair
  modport timer (
    output wake_vld,
    output wake_preg
  );

  // source entries just watch the bus
  modport listen (
    input wake_vld,
    input wake_preg,
    input wake_cancel,
    input wb0_vld,
    input wb0_preg,
    input wb1_vld,
    input wb1_preg
  );

endinterface

`default_nettype wire

// ==== src/dep_src_entry.sv ====
// dep_src_entry: dependency state of one source operand, its tag, ready bit and written-back bit
`timescale 1ns/100ps
`default_nettype none

module dep_src_entry
  import dep_pkg::*;
(
  input  wire               dep_clk,
  input  wire               cpurst_b,
  input  wire               write_en,
  input  wire  [preg_w-1:0] create_preg,
  input  wire               create_rdy,
  dep_bcast_if.listen       bcast,
  output logic              src_rdy
);

  // producer tag of this source
  logic [preg_w-1:0] preg;
  // predicted ready, may rest on a wake-up only
  logic              rdy;
  // value is in the register file
  logic              wb;

  // tag and bits seen this cycle, create values in the write cycle
  logic [preg_w-1:0] cmp_preg;
  logic              base_rdy;
  logic              base_wb;
  logic              wake_hit;
  logic              wb_hit;
  logic              rdy_nxt;
  logic              wb_nxt;

  // ========================================
  // tag
  // ========================================
  always_ff @(posedge dep_clk)
  begin
    if (write_en)
      preg <= create_preg;
  end

  // a broadcast in the create cycle already counts for the new tag
  assign cmp_preg = write_en ? create_preg : preg;
  assign base_rdy = write_en ? create_rdy : rdy;
  assign base_wb  = write_en ? create_rdy : wb;

  // ========================================
  // broadcast match
  // ========================================
  assign wake_hit = bcast.wake_vld && (bcast.wake_preg == cmp_preg);
  assign wb_hit   = (bcast.wb0_vld && (bcast.wb0_preg == cmp_preg))
                 || (bcast.wb1_vld && (bcast.wb1_preg == cmp_preg));

  // written back: hold, or set on either write-back port
  assign wb_nxt  = base_wb || wb_hit;
  // ready: written back always wins
  // otherwise hold or wake, cancel beats a wake in the same cycle
  assign rdy_nxt = wb_nxt || ((base_rdy || wake_hit) && !bcast.wake_cancel);

  // ========================================
  // state bits
  // ========================================
  // idle entries rest ready and written back
  always_ff @(posedge dep_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      rdy <= 1'b1;
      wb  <= 1'b1;
    end
    else
    begin
      rdy <= rdy_nxt;
      wb  <= wb_nxt;
    end
  end

  assign src_rdy = rdy;

  // after a cancel only written-back sources may still look ready
  a_cancel_keeps_wb: assert property (@(posedge dep_clk) disable iff (!cpurst_b)
    bcast.wake_cancel |=> (!rdy || wb));

endmodule

`default_nettype wire

// ==== src/iq_entry.sv ====
// iq_entry: one issue queue slot with valid bit, payload and two source dependency entries
`timescale 1ns/100ps
`default_nettype none

module iq_entry
  import dep_pkg::*;
(
  input  wire               dep_clk,
  input  wire               cpurst_b,
  input  wire               write_en,
  input  wire iq_create_t   create,
  input  wire               free,
  input  wire               flush,
  dep_bcast_if.listen       bcast,
  output logic              entry_vld,
  output logic              entry_rdy,
  output logic [op_w-1:0]   entry_op,
  output logic [preg_w-1:0] entry_dst,
  output logic [lat_w-1:0]  entry_lat
);

  // per-source readiness
  logic src0_rdy;
  logic src1_rdy;

  // ========================================
  // valid bit
  // ========================================
  // flush first, it also kills a create in the same cycle
  always_ff @(posedge dep_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      entry_vld <= 1'b0;
    else if (flush)
      entry_vld <= 1'b0;
    else if (write_en)
      entry_vld <= 1'b1;
    else if (free)
      entry_vld <= 1'b0;
  end

  // payload, only meaningful while valid
  always_ff @(posedge dep_clk)
  begin
    if (write_en)
    begin
      entry_op  <= create.op;
      entry_dst <= create.dst_preg;
      entry_lat <= create.lat;
    end
  end

  // ========================================
  // sources
  // ========================================
  dep_src_entry u_src0 (
    .dep_clk     (dep_clk),
    .cpurst_b    (cpurst_b),
    .write_en    (write_en),
    .create_preg (create.src0_preg),
    .create_rdy  (create.src0_rdy),
    .bcast       (bcast),
    .src_rdy     (src0_rdy)
  );

  dep_src_entry u_src1 (
    .dep_clk     (dep_clk),
    .cpurst_b    (cpurst_b),
    .write_en    (write_en),
    .create_preg (create.src1_preg),
    .create_rdy  (create.src1_rdy),
    .bcast       (bcast),
    .src_rdy     (src1_rdy)
  );

  // issuable once both operands are predicted ready
  assign entry_rdy = entry_vld && src0_rdy && src1_rdy;

  // allocation must only pick a free slot
  a_no_overwrite: assert property (@(posedge dep_clk) disable iff (!cpurst_b)
    write_en |-> !entry_vld);

endmodule

`default_nettype wire

// ==== src/iq_ctrl.sv ====
// iq_ctrl: allocation, lowest-index issue select, issue handshake, replay withdrawal and flush
`timescale 1ns/100ps
`default_nettype none

module iq_ctrl
  import dep_pkg::*;
(
  input  wire                          dep_clk,
  input  wire                          cpurst_b,
  input  wire                          flush,
  input  wire                          create_vld,
  output logic                         create_rdy,
  output logic [iq_depth-1:0]          write_sel,
  input  wire  [iq_depth-1:0]          entry_vld,
  input  wire  [iq_depth-1:0]          entry_rdy,
  output logic [iq_depth-1:0]          free_sel,
  output logic                         flush_all,
  output logic [$clog2(iq_depth)-1:0]  sel_idx,
  output logic                         issue_vld,
  input  wire                          issue_rdy,
  output logic                         issue_fire
);

  iq_state_t                   state;
  iq_state_t                   state_nxt;
  // lowest free slot, one-hot
  logic [iq_depth-1:0]         free_oh;
  // lowest ready slot
  logic [$clog2(iq_depth)-1:0] rdy_idx;
  logic                        any_rdy;
  // offered slot still ready
  logic                        sel_rdy;

  // ========================================
  // priority pick
  // ========================================
  // walk downwards so the lowest index is left standing
  always_comb
  begin
    free_oh = '0;
    rdy_idx = '0;
    for (int i = iq_depth - 1; i >= 0; i--)
    begin
      if (!entry_vld[i])
      begin
        free_oh    = '0;
        free_oh[i] = 1'b1;
      end
      if (entry_rdy[i])
        rdy_idx = i[$clog2(iq_depth)-1:0];
    end
  end

  assign any_rdy = |entry_rdy;
  assign sel_rdy = entry_rdy[sel_idx];

  // allocation
  assign create_rdy = (|(~entry_vld)) && (state != st_flush);
  assign write_sel  = (create_vld && create_rdy) ? free_oh : '0;

  // ========================================
  // state machine
  // ========================================
  always_comb
  begin
    state_nxt = state;
    case (state)
      st_idle:
        if (any_rdy)
          state_nxt = st_offer;
      // leave on a fire, or on replay when the slot lost readiness
      st_offer:
        if (issue_fire || !sel_rdy)
          state_nxt = st_idle;
      default:
        state_nxt = st_idle;
    endcase
    if (flush)
      state_nxt = st_flush;
  end

  always_ff @(posedge dep_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      state <= st_idle;
    else
      state <= state_nxt;
  end

  // choice is frozen while offered, so payload is stable under back-pressure
  always_ff @(posedge dep_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      sel_idx <= '0;
    else if ((state == st_idle) && any_rdy)
      sel_idx <= rdy_idx;
  end

  // ========================================
  // issue handshake
  // ========================================
  // drops only on cancel or flush
  assign issue_vld  = (state == st_offer) && sel_rdy && !flush;
  assign issue_fire = issue_vld && issue_rdy;

  // issued slot leaves on the handshake edge
  always_comb
  begin
    free_sel = '0;
    if (issue_fire)
      free_sel[sel_idx] = 1'b1;
  end

  // slots and timer stay clear through the flush cycle
  assign flush_all = flush || (state == st_flush);

  // an offered slot is always occupied
  a_offer_valid: assert property (@(posedge dep_clk) disable iff (!cpurst_b)
    (state == st_offer) |-> entry_vld[sel_idx]);

endmodule

`default_nettype wire

// ==== src/wake_timer.sv ====
// wake_timer: holds issued destination tags and broadcasts each as a wake-up after its latency
`timescale 1ns/100ps
`default_nettype none

module wake_timer
  import dep_pkg::*;
(
  input  wire               dep_clk,
  input  wire               cpurst_b,
  input  wire               flush,
  input  wire               issue_fire,
  input  wire  [preg_w-1:0] issue_dst,
  input  wire  [lat_w-1:0]  issue_lat,
  dep_bcast_if.timer        bcast
);

  // slot i is released i+1 edges from now, so position is the countdown
  logic [lat_max-1:0]             slot_vld;
  logic [lat_max-1:0][preg_w-1:0] slot_tag;
  logic [lat_max-1:0]             vld_nxt;
  logic [lat_max-1:0][preg_w-1:0] tag_nxt;
  logic [lat_w-1:0]               load_idx;
  logic                           load;

  // wake edge is latency edges after the fire, one spent in the output stage
  assign load_idx = issue_lat - 1'b1;

  // ========================================
  // countdown
  // ========================================
  always_comb
  begin
    // all slots step one closer to release
    vld_nxt = slot_vld >> 1;
    tag_nxt = slot_tag >> preg_w;
    // fire lands in the slot matching its latency
    // an occupied slot keeps the older tag, its consumer waits for write-back
    load = issue_fire && !vld_nxt[load_idx];
    if (load)
    begin
      vld_nxt[load_idx] = 1'b1;
      tag_nxt[load_idx] = issue_dst;
    end
  end

  always_ff @(posedge dep_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      slot_vld       <= '0;
      bcast.wake_vld <= 1'b0;
    end
    else if (flush)
    begin
      slot_vld       <= '0;
      bcast.wake_vld <= 1'b0;
    end
    else
    begin
      slot_vld       <= vld_nxt;
      bcast.wake_vld <= slot_vld[0];
    end
  end

  // tags follow the valid bits
  always_ff @(posedge dep_clk)
  begin
    slot_tag        <= tag_nxt;
    bcast.wake_preg <= slot_tag[0];
  end

  // producers must carry a latency the timer can count
  a_lat_range: assert property (@(posedge dep_clk) disable iff (!cpurst_b)
    issue_fire |-> ((issue_lat >= 1) && (issue_lat <= lat_max)));

endmodule

`default_nettype wire

// ==== src/iq_top.sv ====
// iq_top: four-entry issue queue joining the slots, the controller and the wake-up timer
`timescale 1ns/100ps
`default_nettype none

module iq_top
  import dep_pkg::*;
(
  input  wire               dep_clk,
  input  wire               cpurst_b,
  // create port
  input  wire               create_vld,
  output logic              create_rdy,
  input  wire  [op_w-1:0]   create_op,
  input  wire  [preg_w-1:0] create_dst_preg,
  input  wire  [lat_w-1:0]  create_lat,
  input  wire  [preg_w-1:0] create_src0_preg,
  input  wire               create_src0_rdy,
  input  wire  [preg_w-1:0] create_src1_preg,
  input  wire               create_src1_rdy,
  // write-back, cancel and flush
  input  wire               wb0_vld,
  input  wire  [preg_w-1:0] wb0_preg,
  input  wire               wb1_vld,
  input  wire  [preg_w-1:0] wb1_preg,
  input  wire               wake_cancel,
  input  wire               flush,
  // issue port
  output logic              issue_vld,
  input  wire               issue_rdy,
  output logic [op_w-1:0]   issue_op,
  output logic [preg_w-1:0] issue_dst_preg,
  output logic [lat_w-1:0]  issue_lat
);

  iq_create_t                  create_pkt;
  wire  [iq_depth-1:0]         write_sel;
  wire  [iq_depth-1:0]         free_sel;
  wire  [iq_depth-1:0]         entry_vld;
  wire  [iq_depth-1:0]         entry_rdy;
  wire  [op_w-1:0]             entry_op  [iq_depth];
  wire  [preg_w-1:0]           entry_dst [iq_depth];
  wire  [lat_w-1:0]            entry_lat [iq_depth];
  logic                        flush_all;
  logic                        issue_fire;
  logic [$clog2(iq_depth)-1:0] sel_idx;

  // ========================================
  // broadcast bus
  // ========================================
  dep_bcast_if bcast ();

  // external broadcasts, wake pair comes from the timer
  assign bcast.wake_cancel = wake_cancel;
  assign bcast.wb0_vld     = wb0_vld;
  assign bcast.wb0_preg    = wb0_preg;
  assign bcast.wb1_vld     = wb1_vld;
  assign bcast.wb1_preg    = wb1_preg;

  // create packet, same for every slot
  assign create_pkt = '{
    op:        create_op,
    dst_preg:  create_dst_preg,
    lat:       create_lat,
    src0_preg: create_src0_preg,
    src0_rdy:  create_src0_rdy,
    src1_preg: create_src1_preg,
    src1_rdy:  create_src1_rdy
  };

  // ========================================
  // slots
  // ========================================
  for (genvar i = 0; i < iq_depth; i++)
  begin : g_slot
    iq_entry u_entry (
      .dep_clk   (dep_clk),
      .cpurst_b  (cpurst_b),
      .write_en  (write_sel[i]),
      .create    (create_pkt),
      .free      (free_sel[i]),
      .flush     (flush_all),
      .bcast     (bcast),
      .entry_vld (entry_vld[i]),
      .entry_rdy (entry_rdy[i]),
      .entry_op  (entry_op[i]),
      .entry_dst (entry_dst[i]),
      .entry_lat (entry_lat[i])
    );
  end

  iq_ctrl u_ctrl (
    .dep_clk    (dep_clk),
    .cpurst_b   (cpurst_b),
    .flush      (flush),
    .create_vld (create_vld),
    .create_rdy (create_rdy),
    .write_sel  (write_sel),
    .entry_vld  (entry_vld),
    .entry_rdy  (entry_rdy),
    .free_sel   (free_sel),
    .flush_all  (flush_all),
    .sel_idx    (sel_idx),
    .issue_vld  (issue_vld),
    .issue_rdy  (issue_rdy),
    .issue_fire (issue_fire)
  );

  // offered payload
  assign issue_op       = entry_op[sel_idx];
  assign issue_dst_preg = entry_dst[sel_idx];
  assign issue_lat      = entry_lat[sel_idx];

  wake_timer u_timer (
    .dep_clk    (dep_clk),
    .cpurst_b   (cpurst_b),
    .flush      (flush_all),
    .issue_fire (issue_fire),
    .issue_dst  (issue_dst_preg),
    .issue_lat  (issue_lat),
    .bcast      (bcast)
  );

endmodule

`default_nettype wire

// ==== tb/iq_tb.sv ====
// directed testbench for the four-entry issue queue and its dependency tracking
`timescale 1ns/100ps
`default_nettype none

module iq_tb
  import dep_pkg::*;
();

  logic              dep_clk;
  logic              cpurst_b;
  logic              create_vld;
  logic              create_rdy;
  logic [op_w-1:0]   new_op;
  logic [preg_w-1:0] new_dst;
  logic [lat_w-1:0]  new_lat;
  logic [preg_w-1:0] new_s0_preg;
  logic              new_s0_rdy;
  logic [preg_w-1:0] new_s1_preg;
  logic              new_s1_rdy;
  logic              wb0_vld;
  logic [preg_w-1:0] wb0_preg;
  logic              wb1_vld;
  logic [preg_w-1:0] wb1_preg;
  logic              wake_cancel;
  logic              flush;
  logic              issue_vld;
  logic              issue_rdy;
  logic [op_w-1:0]   issue_op;
  logic [preg_w-1:0] issue_dst_preg;
  logic [lat_w-1:0]  issue_lat;

  // expected payloads by creation order within a test
  logic [op_w-1:0]   exp_op  [4];
  logic [preg_w-1:0] exp_dst [4];
  logic [lat_w-1:0]  exp_lat [4];

  iq_top UUT (
    .dep_clk          (dep_clk),
    .cpurst_b         (cpurst_b),
    .create_vld       (create_vld),
    .create_rdy       (create_rdy),
    .create_op        (new_op),
    .create_dst_preg  (new_dst),
    .create_lat       (new_lat),
    .create_src0_preg (new_s0_preg),
    .create_src0_rdy  (new_s0_rdy),
    .create_src1_preg (new_s1_preg),
    .create_src1_rdy  (new_s1_rdy),
    .wb0_vld          (wb0_vld),
    .wb0_preg         (wb0_preg),
    .wb1_vld          (wb1_vld),
    .wb1_preg         (wb1_preg),
    .wake_cancel      (wake_cancel),
    .flush            (flush),
    .issue_vld        (issue_vld),
    .issue_rdy        (issue_rdy),
    .issue_op         (issue_op),
    .issue_dst_preg   (issue_dst_preg),
    .issue_lat        (issue_lat)
  );

  // 40 ns clock
  initial
  begin
    dep_clk = 1'b0;
    forever
      #20 dep_clk = ~dep_clk;
  end

  // ========================================
  // helpers
  // ========================================
  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Test FAILED");
    $fatal(1, "simulation stopped at first failure");
  endtask

  // producer tags kept in the upper half
  // fixed dependency tags stay below
  task automatic pick_payload(input int k);
    exp_op[k]  = 8'($urandom);
    exp_dst[k] = 7'h40 | 7'($urandom % 64);
    exp_lat[k] = 2'(1 + $urandom % 3);
  endtask

  task automatic create_op(input logic [op_w-1:0] op, input logic [preg_w-1:0] dst,
                           input logic [lat_w-1:0] lat, input logic [preg_w-1:0] s0_preg,
                           input logic s0_rdy, input logic [preg_w-1:0] s1_preg,
                           input logic s1_rdy);
    int cnt;
    cnt = 0;
    @(posedge dep_clk);
    create_vld  <= 1'b1;
    new_op      <= op;
    new_dst     <= dst;
    new_lat     <= lat;
    new_s0_preg <= s0_preg;
    new_s0_rdy  <= s0_rdy;
    new_s1_preg <= s1_preg;
    new_s1_rdy  <= s1_rdy;
    // accepted on the edge after create_rdy is seen high
    do
    begin
      @(negedge dep_clk);
      cnt++;
      assert (cnt <= 200)
      else
        abort_run("timeout: create_rdy stayed low for 200 cycles");
    end
    while (!create_rdy);
    @(posedge dep_clk);
    create_vld <= 1'b0;
  endtask

  // returns at a falling edge with issue_vld high
  task automatic wait_offer();
    int cnt;
    cnt = 0;
    do
    begin
      @(negedge dep_clk);
      cnt++;
      assert (cnt <= 200)
      else
        abort_run("timeout: issue_vld did not rise within 200 cycles");
    end
    while (!issue_vld);
  endtask

  task automatic check_payload(input int k);
    assert (issue_op == exp_op[k])
    else
      abort_run($sformatf("error at %0t ns: issue_op %0h, expected %0h",
                          $time, issue_op, exp_op[k]));
    assert (issue_dst_preg == exp_dst[k])
    else
      abort_run($sformatf("error at %0t ns: issue_dst_preg %0h, expected %0h",
                          $time, issue_dst_preg, exp_dst[k]));
    assert (issue_lat == exp_lat[k])
    else
      abort_run($sformatf("error at %0t ns: issue_lat %0d, expected %0d",
                          $time, issue_lat, exp_lat[k]));
  endtask

  // accept exactly one instruction and check what it carries
  task automatic wait_issue(input int k);
    @(posedge dep_clk);
    issue_rdy <= 1'b1;
    wait_offer();
    check_payload(k);
    // handshake completes on this edge
    @(posedge dep_clk);
    issue_rdy <= 1'b0;
  endtask

  task automatic pulse_wb(input int port, input logic [preg_w-1:0] tag);
    @(posedge dep_clk);
    if (port == 0)
    begin
      wb0_vld  <= 1'b1;
      wb0_preg <= tag;
    end
    else
    begin
      wb1_vld  <= 1'b1;
      wb1_preg <= tag;
    end
    @(posedge dep_clk);
    wb0_vld <= 1'b0;
    wb1_vld <= 1'b0;
  endtask

  task automatic expect_quiet(input int n);
    repeat (n)
    begin
      @(negedge dep_clk);
      assert (!issue_vld)
      else
        abort_run($sformatf("error at %0t ns: issue_vld high, none expected", $time));
    end
  endtask

  // ========================================
  // tests
  // ========================================
  // lowest free slot fills first
  // lowest ready index issues first
  task automatic test_in_order();
    for (int k = 0; k < 3; k++)
    begin
      pick_payload(k);
      create_op(exp_op[k], exp_dst[k], exp_lat[k], 7'($urandom), 1'b1, 7'($urandom), 1'b1);
    end
    for (int k = 0; k < 3; k++)
      wait_issue(k);
  endtask

  task automatic test_wb_wake();
    pick_payload(0);
    create_op(exp_op[0], exp_dst[0], exp_lat[0], 7'h11, 1'b0, 7'($urandom), 1'b1);
    expect_quiet(10);
    // wrong tag, still waiting
    pulse_wb(0, 7'h10);
    expect_quiet(10);
    pulse_wb(1, 7'h11);
    wait_issue(0);
  endtask

  // dependant wakes from the timer alone
  // no write-back at all
  task automatic test_spec_wake();
    pick_payload(0);
    pick_payload(1);
    exp_dst[0] = 7'h22;
    exp_lat[0] = 2'd2;
    create_op(exp_op[0], exp_dst[0], exp_lat[0], 7'($urandom), 1'b1, 7'($urandom), 1'b1);
    create_op(exp_op[1], exp_dst[1], exp_lat[1], 7'h22, 1'b0, 7'($urandom), 1'b1);
    wait_issue(0);
    wait_issue(1);
  endtask

  task automatic test_backpressure();
    for (int k = 0; k < 4; k++)
      pick_payload(k);
    create_op(exp_op[0], exp_dst[0], exp_lat[0], 7'($urandom), 1'b1, 7'($urandom), 1'b1);
    wait_offer();
    check_payload(0);
    // offer must hold still while issue_rdy is low
    repeat (10)
    begin
      @(negedge dep_clk);
      assert (issue_vld)
      else
        abort_run($sformatf("error at %0t ns: issue_vld dropped under back-pressure", $time));
      check_payload(0);
    end
    for (int k = 1; k < 4; k++)
      create_op(exp_op[k], exp_dst[k], exp_lat[k], 7'($urandom), 1'b1, 7'($urandom), 1'b1);
    @(negedge dep_clk);
    assert (!create_rdy)
    else
      abort_run($sformatf("error at %0t ns: create_rdy high with all slots full", $time));
    wait_issue(0);
    @(negedge dep_clk);
    assert (create_rdy)
    else
      abort_run($sformatf("error at %0t ns: create_rdy low after an issue", $time));
    for (int k = 1; k < 4; k++)
      wait_issue(k);
  endtask

  // cancel withdraws the speculative offer
  // a write-back restores it
  task automatic test_replay();
    pick_payload(0);
    pick_payload(1);
    exp_dst[0] = 7'h33;
    exp_lat[0] = 2'd1;
    create_op(exp_op[0], exp_dst[0], exp_lat[0], 7'($urandom), 1'b1, 7'($urandom), 1'b1);
    create_op(exp_op[1], exp_dst[1], exp_lat[1], 7'h33, 1'b0, 7'($urandom), 1'b1);
    wait_issue(0);
    wait_offer();
    check_payload(1);
    @(posedge dep_clk);
    wake_cancel <= 1'b1;
    @(posedge dep_clk);
    wake_cancel <= 1'b0;
    expect_quiet(10);
    pulse_wb(0, 7'h33);
    wait_issue(1);
  endtask

  task automatic test_flush();
    for (int k = 0; k < 4; k++)
      pick_payload(k);
    create_op(exp_op[0], exp_dst[0], exp_lat[0], 7'($urandom), 1'b1, 7'($urandom), 1'b1);
    create_op(exp_op[1], exp_dst[1], exp_lat[1], 7'($urandom), 1'b1, 7'($urandom), 1'b1);
    create_op(exp_op[2], exp_dst[2], exp_lat[2], 7'h3c, 1'b0, 7'($urandom), 1'b1);
    create_op(exp_op[3], exp_dst[3], exp_lat[3], 7'($urandom), 1'b1, 7'($urandom), 1'b1);
    wait_offer();
    @(posedge dep_clk);
    flush <= 1'b1;
    @(negedge dep_clk);
    assert (!issue_vld)
    else
      abort_run($sformatf("error at %0t ns: issue_vld high during flush", $time));
    @(posedge dep_clk);
    flush <= 1'b0;
    // one cycle in the flush state
    @(posedge dep_clk);
    // queue was full, only the flush frees a slot
    @(negedge dep_clk);
    assert (create_rdy)
    else
      abort_run($sformatf("error at %0t ns: create_rdy low after flush", $time));
    // old ops would fire here if any survived
    @(posedge dep_clk);
    issue_rdy <= 1'b1;
    expect_quiet(10);
    @(posedge dep_clk);
    issue_rdy <= 1'b0;
    pick_payload(0);
    create_op(exp_op[0], exp_dst[0], exp_lat[0], 7'($urandom), 1'b1, 7'($urandom), 1'b1);
    wait_issue(0);
  endtask

  // ========================================
  // main sequence
  // ========================================
  initial
  begin
    void'($urandom(32'h22e6));
    cpurst_b    <= 1'b0;
    create_vld  <= 1'b0;
    new_op      <= '0;
    new_dst     <= '0;
    new_lat     <= 2'd1;
    new_s0_preg <= '0;
    new_s0_rdy  <= 1'b1;
    new_s1_preg <= '0;
    new_s1_rdy  <= 1'b1;
    wb0_vld     <= 1'b0;
    wb0_preg    <= '0;
    wb1_vld     <= 1'b0;
    wb1_preg    <= '0;
    wake_cancel <= 1'b0;
    flush       <= 1'b0;
    issue_rdy   <= 1'b0;
    repeat (5)
      @(posedge dep_clk);
    cpurst_b <= 1'b1;
    @(negedge dep_clk);
    assert (create_rdy && !issue_vld)
    else
      abort_run($sformatf("error at %0t ns: wrong handshake state after reset", $time));
    test_in_order();
    test_wb_wake();
    test_spec_wake();
    test_backpressure();
    test_replay();
    test_flush();
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
src/dep_pkg.sv
src/dep_bcast_if.sv
src/dep_src_entry.sv
src/iq_entry.sv
src/iq_ctrl.sv
src/wake_timer.sv
src/iq_top.sv
tb/iq_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the issue queue testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module iq_tb -f flist.f -o Viq_tb

# the testbench stops with a non-zero status on failure, the log decides
./obj_dir/Viq_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test OK" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation did not pass, see sim.log"
  exit 1
fi
